// ==== dmem_settings.svh ====
`ifndef DMEM_SETTINGS_SVH
`define DMEM_SETTINGS_SVH

// number of 32-bit words in the data RAM, power of two
`define DMEM_WORDS 256

// request buffer entries, also the client's starting credit
`define REQ_FIFO_DEPTH 4

`endif

// ==== mem_types_pkg.sv ====
`include "dmem_settings.svh"

package mem_types_pkg;

    localparam int IDX_W = $clog2(`DMEM_WORDS); // word index width

    typedef logic [31:0] addr_t;       // byte address
    typedef logic [31:0] word_t;       // one RAM word
    typedef logic [IDX_W-1:0] word_idx_t; // word index, wraps with RAM size
    typedef logic [1:0] size_t;        // access size code

    // size codes as sent by the client, code 3 unused
    localparam size_t SIZE_B = 2'd0;   // byte
    localparam size_t SIZE_H = 2'd1;   // half-word
    localparam size_t SIZE_W = 2'd2;   // word

endpackage

// ==== access_fsm_pkg.sv ====
package access_fsm_pkg;

    typedef enum logic [3:0] {
        IDLE,          // waiting for a request
        STORE_CHECK,   // store taken, read needed or not
        READ1,         // first word read issued
        WAIT1,         // first word captured
        READ2,         // second word read issued
        WAIT2,         // second word captured
        MERGE,         // load result and store words built
        WRITE1,        // first word written back
        WRITE2,        // second word written back
        PUSH           // load response out
    } access_state_t;

endpackage

// ==== req_fifo.sv ====
`timescale 1ns/10ps
`include "dmem_settings.svh"

module req_fifo import mem_types_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  req_valid,
    input  logic  req_wen,
    input  size_t req_size,
    input  addr_t req_addr,
    input  word_t req_wdata,
    input  logic  pop,
    output logic  head_valid,
    output logic  head_wen,
    output size_t head_size,
    output addr_t head_addr,
    output word_t head_wdata,
    output logic  req_credit
);

    localparam int DEPTH = `REQ_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic  wen_mem   [DEPTH];
    size_t size_mem  [DEPTH];
    addr_t addr_mem  [DEPTH];
    word_t wdata_mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // pointer increment, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // entry payload, credits keep this from overrunning
    always_ff @(posedge clk) begin
        if (req_valid) begin
            wen_mem[wr_ptr]   <= req_wen;
            size_mem[wr_ptr]  <= req_size;
            addr_mem[wr_ptr]  <= req_addr;
            wdata_mem[wr_ptr] <= req_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            req_credit <= 1'b0;
        end else begin
            req_credit <= pop; // one credit back per dequeue
            if (req_valid) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            if (req_valid && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !req_valid) begin
                count <= count - 1'b1;
            end
        end
    end

    assign head_valid = (count != '0);
    assign head_wen   = wen_mem[rd_ptr];
    assign head_size  = size_mem[rd_ptr];
    assign head_addr  = addr_mem[rd_ptr];
    assign head_wdata = wdata_mem[rd_ptr];

endmodule

// ==== word_ram.sv ====
`timescale 1ns/10ps
`include "dmem_settings.svh"

module word_ram import mem_types_pkg::*; (
    input  logic      clk,
    input  logic      mem_en,
    input  logic      mem_wen,
    input  word_idx_t mem_idx,
    input  word_t     mem_wdata,
    output word_t     mem_rdata
);

    word_t mem [`DMEM_WORDS];

    // single port, a write leaves the read register unchanged
    always_ff @(posedge clk) begin
        if (mem_en) begin
            if (mem_wen) begin
                mem[mem_idx] <= mem_wdata;
            end else begin
                mem_rdata <= mem[mem_idx]; // valid the cycle after the read
            end
        end
    end

endmodule

// ==== misaligned_access_unit.sv ====
`timescale 1ns/10ps

module misaligned_access_unit
    import mem_types_pkg::*;
    import access_fsm_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      head_valid,
    input  logic      head_wen,
    input  size_t     head_size,
    input  addr_t     head_addr,
    input  word_t     head_wdata,
    input  word_t     mem_rdata,
    output logic      pop,
    output logic      mem_en,
    output logic      mem_wen,
    output word_idx_t mem_idx,
    output word_t     mem_wdata,
    output logic      resp_valid,
    output addr_t     resp_addr,
    output word_t     resp_rdata
);

    access_state_t state;

    // request taken at pop
    logic  req_wen;
    size_t req_size;
    addr_t req_addr;
    word_t req_wdata;

    word_t rd_word1;    // first aligned word read
    word_t rd_word2;    // second aligned word read
    word_t wr_word1;    // first word to write back
    word_t wr_word2;    // second word to write back
    word_t load_result;

    logic [1:0]  byte_off;
    logic        two_words;
    logic        need_read;
    word_idx_t   idx1;
    word_idx_t   idx2;
    logic [3:0]  size_mask;
    logic [31:0] size_bits;
    logic [7:0]  byte_en;
    logic [63:0] bit_en;
    logic [4:0]  bit_shift;
    logic [63:0] pair_rd;
    logic [63:0] pair_shifted;
    logic [63:0] store_data;
    logic [63:0] pair_wr;

    assign byte_off  = req_addr[1:0];
    assign bit_shift = {byte_off, 3'b000};

    // half at offset 3 or word off alignment spills into the next word
    assign two_words = (req_size == SIZE_H && byte_off == 2'd3) ||
                       (req_size == SIZE_W && byte_off != 2'd0);

    // only an aligned full word can be written blind
    assign need_read = !(req_size == SIZE_W && byte_off == 2'd0);

    assign idx1 = req_addr[IDX_W+1:2];
    assign idx2 = idx1 + word_idx_t'(1); // wraps past the last word

    always_comb begin
        case (req_size)
            SIZE_B:  size_mask = 4'b0001;
            SIZE_H:  size_mask = 4'b0011;
            SIZE_W:  size_mask = 4'b1111;
            default: size_mask = 4'b0000;
        endcase
    end

    assign byte_en = {4'b0000, size_mask} << byte_off;

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            size_bits[8*i +: 8] = {8{size_mask[i]}};
        end
        for (int i = 0; i < 8; i++) begin
            bit_en[8*i +: 8] = {8{byte_en[i]}};
        end
    end

    // little-endian pair, first word in the low half
    assign pair_rd      = {rd_word2, rd_word1};
    assign pair_shifted = pair_rd >> bit_shift;
    assign store_data   = {32'h0, req_wdata} << bit_shift;
    assign pair_wr      = (pair_rd & ~bit_en) | (store_data & bit_en);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (pop) begin
                        if (head_wen) begin
                            state <= STORE_CHECK;
                        end else begin
                            state <= READ1;
                        end
                    end
                end
                STORE_CHECK: begin
                    if (need_read) begin
                        state <= READ1;
                    end else begin
                        state <= WRITE1;
                    end
                end
                READ1: state <= WAIT1;
                WAIT1: begin
                    if (two_words) begin
                        state <= READ2;
                    end else begin
                        state <= MERGE;
                    end
                end
                READ2: state <= WAIT2;
                WAIT2: state <= MERGE;
                MERGE: begin
                    if (req_wen) begin
                        state <= WRITE1;
                    end else begin
                        state <= PUSH;
                    end
                end
                WRITE1: begin
                    if (two_words) begin
                        state <= WRITE2;
                    end else begin
                        state <= IDLE;
                    end
                end
                WRITE2:  state <= IDLE;
                PUSH:    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            req_wen   <= head_wen;
            req_size  <= head_size;
            req_addr  <= head_addr;
            req_wdata <= head_wdata;
        end
        if (state == WAIT1) begin
            rd_word1 <= mem_rdata;
        end
        if (state == WAIT2) begin
            rd_word2 <= mem_rdata;
        end
        if (state == STORE_CHECK) begin
            wr_word1 <= req_wdata; // used as is when no read follows
        end
        if (state == MERGE) begin
            wr_word1    <= pair_wr[31:0];
            wr_word2    <= pair_wr[63:32];
            load_result <= pair_shifted[31:0] & size_bits; // zero-extended
        end
    end

    assign pop       = (state == IDLE) && head_valid;
    assign mem_en    = (state == READ1) || (state == READ2) ||
                       (state == WRITE1) || (state == WRITE2);
    assign mem_wen   = (state == WRITE1) || (state == WRITE2);
    assign mem_idx   = (state == READ2 || state == WRITE2) ? idx2 : idx1;
    assign mem_wdata = (state == WRITE2) ? wr_word2 : wr_word1;

    assign resp_valid = (state == PUSH);
    assign resp_addr  = req_addr;
    assign resp_rdata = load_result;

endmodule

// ==== dmem_subsystem.sv ====
`timescale 1ns/10ps

module dmem_subsystem import mem_types_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  req_valid,
    input  logic  req_wen,
    input  size_t req_size,
    input  addr_t req_addr,
    input  word_t req_wdata,
    output logic  req_credit,
    output logic  resp_valid,
    output addr_t resp_addr,
    output word_t resp_rdata
);

    // buffer head to access unit
    logic  head_valid;
    logic  head_wen;
    size_t head_size;
    addr_t head_addr;
    word_t head_wdata;
    logic  pop;

    // access unit to RAM
    logic      mem_en;
    logic      mem_wen;
    word_idx_t mem_idx;
    word_t     mem_wdata;
    word_t     mem_rdata;

    req_fifo req_fifo_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_wen    (req_wen),
        .req_size   (req_size),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .pop        (pop),
        .head_valid (head_valid),
        .head_wen   (head_wen),
        .head_size  (head_size),
        .head_addr  (head_addr),
        .head_wdata (head_wdata),
        .req_credit (req_credit)
    );

    misaligned_access_unit misaligned_access_unit_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .head_valid (head_valid),
        .head_wen   (head_wen),
        .head_size  (head_size),
        .head_addr  (head_addr),
        .head_wdata (head_wdata),
        .mem_rdata  (mem_rdata),
        .pop        (pop),
        .mem_en     (mem_en),
        .mem_wen    (mem_wen),
        .mem_idx    (mem_idx),
        .mem_wdata  (mem_wdata),
        .resp_valid (resp_valid),
        .resp_addr  (resp_addr),
        .resp_rdata (resp_rdata)
    );

    word_ram word_ram_inst (
        .clk       (clk),
        .mem_en    (mem_en),
        .mem_wen   (mem_wen),
        .mem_idx   (mem_idx),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

endmodule

// ==== tb_dmem_subsystem.sv ====
`timescale 1ns/10ps
`include "dmem_settings.svh"

module tb_dmem_subsystem import mem_types_pkg::*; ();

    localparam int MEM_BYTES      = 4 * `DMEM_WORDS;
    localparam int DEPTH          = `REQ_FIFO_DEPTH;
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int LOW_BYTES      = 64; // words 0 to 15

    logic  clk;
    logic  rst_n;
    logic  req_valid;
    logic  req_wen;
    size_t req_size;
    addr_t req_addr;
    word_t req_wdata;
    logic  req_credit;
    logic  resp_valid;
    addr_t resp_addr;
    word_t resp_rdata;

    logic [7:0] model_mem [MEM_BYTES]; // byte-wide reference, little-endian
    addr_t exp_addr_q [$];
    word_t exp_data_q [$];
    addr_t exp_addr;
    word_t exp_data;

    integer seed;
    int     credits;
    int     credit_total;
    int     sent_total;
    int     error_count;
    int     tests_passed;
    int     tests_failed;
    int     errors_before;
    int     nbytes;
    size_t  test_size;
    addr_t  test_addr;
    bit     timed_out;

    dmem_subsystem dmem_subsystem_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_wen    (req_wen),
        .req_size   (req_size),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_credit (req_credit),
        .resp_valid (resp_valid),
        .resp_addr  (resp_addr),
        .resp_rdata (resp_rdata)
    );

    always #5 clk = ~clk;

    function automatic int rand_below(input int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n   = 1'b1;
        credits = DEPTH; // client starts with a full buffer's worth
    endtask

    // one request, spends a credit, updates the model at send time
    task automatic send_req(input logic wen, input size_t size, input addr_t addr,
                            input word_t wdata);
        int    waited;
        int    count;
        word_t expected;
        waited   = 0;
        count    = 1 << size;
        expected = '0;
        while (credits == 0 && waited < TIMEOUT_CYCLES && !timed_out) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (timed_out) return;
        if (credits == 0) begin
            $display("timeout: no credit came back within %0d cycles", TIMEOUT_CYCLES);
            timed_out = 1'b1;
            error_count++;
            return;
        end
        req_valid = 1'b1;
        req_wen   = wen;
        req_size  = size;
        req_addr  = addr;
        req_wdata = wdata;
        credits--;
        sent_total++;
        if (wen) begin
            for (int i = 0; i < count; i++) begin
                model_mem[(addr + i) % MEM_BYTES] = wdata[8*i +: 8];
            end
        end else begin
            for (int i = 0; i < count; i++) begin
                expected[8*i +: 8] = model_mem[(addr + i) % MEM_BYTES];
            end
            exp_addr_q.push_back(addr);
            exp_data_q.push_back(expected); // upper bytes stay zero
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    // wait for all loads answered and all credits home
    task automatic drain();
        int waited;
        waited = 0;
        while ((exp_addr_q.size() != 0 || credits != DEPTH) && waited < TIMEOUT_CYCLES
               && !timed_out) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!timed_out && (exp_addr_q.size() != 0 || credits != DEPTH)) begin
            $display("timeout: %0d loads still unanswered, %0d credits held after %0d cycles",
                     exp_addr_q.size(), credits, TIMEOUT_CYCLES);
            timed_out = 1'b1;
            error_count++;
        end
    endtask

    task automatic finish_test(input string name, input int errors_at_start);
        if (error_count == errors_at_start) begin
            $display("test %s: passed", name);
            tests_passed++;
        end else begin
            $display("test %s: failed with %0d errors", name, error_count - errors_at_start);
            tests_failed++;
        end
    endtask

    // sampled away from the rising edge
    always @(negedge clk) begin
        if (rst_n === 1'b1) begin
            if (req_credit === 1'b1) begin
                credits++;
                credit_total++;
                if (credits > DEPTH) begin
                    $display("credit returned with no request outstanding");
                    error_count++;
                end
            end
            if (resp_valid === 1'b1) begin
                if (exp_addr_q.size() == 0) begin
                    $display("load response arrived with no load outstanding");
                    error_count++;
                end else begin
                    exp_addr = exp_addr_q.pop_front();
                    exp_data = exp_data_q.pop_front();
                    if (resp_addr !== exp_addr) begin
                        $display("ERROR resp_addr: expected %h, got %h", exp_addr, resp_addr);
                        error_count++;
                    end
                    if (resp_rdata !== exp_data) begin
                        $display("ERROR resp_rdata: expected %h, got %h (addr %h)",
                                 exp_data, resp_rdata, exp_addr);
                        error_count++;
                    end
                end
            end
        end
    end

    initial begin
        seed         = 27233;
        clk          = 1'b0;
        rst_n        = 1'b0;
        req_valid    = 1'b0;
        req_wen      = 1'b0;
        req_size     = SIZE_B;
        req_addr     = '0;
        req_wdata    = '0;
        credits      = 0;
        credit_total = 0;
        sent_total   = 0;
        error_count  = 0;
        tests_passed = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        apply_reset();

        errors_before = error_count;
        for (int w = 0; w < 16; w++) begin
            send_req(1'b1, SIZE_W, addr_t'(4 * w), $random(seed));
        end
        for (int w = 0; w < 16; w++) begin
            send_req(1'b0, SIZE_W, addr_t'(4 * w), '0);
        end
        drain();
        finish_test("aligned word store and load", errors_before);

        errors_before = error_count;
        send_req(1'b0, SIZE_H, addr_t'(7), '0); // half at offset 3 spans two words
        for (int n = 0; n < 40; n++) begin
            test_size = size_t'(rand_below(2));
            nbytes    = 1 << test_size;
            test_addr = addr_t'(rand_below(LOW_BYTES - nbytes + 1));
            send_req(1'b0, test_size, test_addr, '0);
        end
        drain();
        finish_test("byte and half-word loads", errors_before);

        errors_before = error_count;
        send_req(1'b1, SIZE_W, addr_t'(MEM_BYTES - 4), $random(seed)); // last RAM word
        for (int k = 1; k < 4; k++) begin
            send_req(1'b0, SIZE_W, addr_t'(MEM_BYTES - 4 + k), '0); // wraps to word 0
        end
        for (int n = 0; n < 20; n++) begin
            test_addr = addr_t'(4 * rand_below(15) + 1 + rand_below(3));
            send_req(1'b0, SIZE_W, test_addr, '0);
        end
        drain();
        finish_test("unaligned word loads", errors_before);

        errors_before = error_count;
        for (int n = 0; n < 30; n++) begin
            test_size = size_t'(rand_below(3));
            nbytes    = 1 << test_size;
            test_addr = addr_t'(rand_below(LOW_BYTES - nbytes + 1));
            send_req(1'b1, test_size, test_addr, $random(seed));
            for (int m = 0; m < 2; m++) begin
                test_size = size_t'(rand_below(3));
                nbytes    = 1 << test_size;
                test_addr = addr_t'(rand_below(LOW_BYTES - nbytes + 1));
                send_req(1'b0, test_size, test_addr, '0);
            end
        end
        drain();
        finish_test("mixed stores with loads", errors_before);

        errors_before = error_count;
        apply_reset(); // RAM and model keep their contents
        credit_total = 0;
        sent_total   = 0;
        for (int n = 0; n < DEPTH; n++) begin
            test_size = size_t'(rand_below(3));
            nbytes    = 1 << test_size;
            test_addr = addr_t'(rand_below(LOW_BYTES - nbytes + 1));
            send_req(n[0] == 1'b0, test_size, test_addr, $random(seed));
        end
        drain();
        repeat (20) @(posedge clk); // room for any stray response
        #1;
        if (credit_total != sent_total) begin
            $display("credit count wrong: %0d requests sent, %0d credits returned",
                     sent_total, credit_total);
            error_count++;
        end
        finish_test("credit flow", errors_before);

        $display("tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+.
mem_types_pkg.sv
access_fsm_pkg.sv
req_fifo.sv
word_ram.sv
misaligned_access_unit.sv
dmem_subsystem.sv
tb_dmem_subsystem.sv
